/* logic/rv_config.svh */
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// ------------------------------------------------------------
// Memory geometry
// ------------------------------------------------------------

// Instruction memory, in 32-bit words.
`define RV_IMEM_DEPTH 256
`define RV_IMEM_AW    8

// Data memory, in 32-bit words.
`define RV_DMEM_DEPTH 256
`define RV_DMEM_AW    8

// Byte address bits below the word index.
`define RV_WORD_OFS   2

`endif

/* logic/rv_pkg.sv */
`include "rv_config.svh"

package rv_pkg;

    // ------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------
    typedef logic [31:0]              word_t;      // Data, instruction or address.
    typedef logic [4:0]               reg_idx_t;   // Register number x0..x31.
    typedef logic [`RV_IMEM_AW-1:0]   imem_idx_t;  // Instruction word index.
    typedef logic [`RV_DMEM_AW-1:0]   dmem_idx_t;  // Data word index.

    // ------------------------------------------------------------
    // ALU operation
    // ------------------------------------------------------------
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,  // Also used for load/store addresses.
        ALU_SUB = 3'd1,  // Also used for the BEQ compare.
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5   // Signed less-than, 1 or 0.
    } alu_op_e;

    // ------------------------------------------------------------
    // Decoder outputs, 9 bits
    // ------------------------------------------------------------
    typedef struct packed {
        logic    reg_write;    // Write rd at the end of the cycle.
        logic    alu_src_imm;  // Operand b is the immediate.
        logic    mem_write;    // Store rs2 to memory.
        logic    mem_to_reg;   // Write-back takes the loaded word.
        logic    branch;       // BEQ, taken when the ALU result is zero.
        alu_op_e alu_op;       // Operation for the ALU.
        logic    illegal;      // Unsupported encoding, runs as a no-op.
    } ctrl_t;

    // ------------------------------------------------------------
    // Data-memory request, 65 bits
    // ------------------------------------------------------------
    typedef struct packed {
        logic  we;     // Write strobe.
        word_t addr;   // Byte address, word aligned.
        word_t wdata;  // Store data.
    } dmem_req_t;

endpackage

/* logic/rv_imem.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_imem
    import rv_pkg::*;
#(
    parameter int DEPTH = `RV_IMEM_DEPTH
) (
    input  logic      CLK,
    input  logic      rst_n,
    input  logic      prog_we,    // Load strobe, honoured only in reset.
    input  imem_idx_t prog_idx,
    input  word_t     prog_data,
    input  imem_idx_t idx,        // Fetch index from the core.
    output word_t     idata
);

    word_t mem [DEPTH];  // Program store, no reset.

    // Program load. The core is held in reset while the image goes in.
    always_ff @(posedge CLK) begin
        if (!rst_n && prog_we && (int'(prog_idx) < DEPTH)) begin
            mem[prog_idx] <= prog_data;
        end
    end

    // Fetch is combinational; out-of-range words read as zero.
    always_comb begin
        if (int'(idx) < DEPTH) begin
            idata = mem[idx];
        end else begin
            idata = '0;  // Opcode 0 decodes as illegal.
        end
    end

endmodule

/* logic/rv_decoder.sv */
`timescale 1ns/1ps

module rv_decoder
    import rv_pkg::*;
(
    input  word_t    instr,
    output ctrl_t    ctrl,
    output word_t    imm,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    output reg_idx_t rd
);

    // ------------------------------------------------------------
    // Opcodes of the supported subset
    // ------------------------------------------------------------
    localparam logic [6:0] OP_REG    = 7'b0110011;  // ADD SUB AND OR XOR SLT.
    localparam logic [6:0] OP_IMM    = 7'b0010011;  // ADDI.
    localparam logic [6:0] OP_LOAD   = 7'b0000011;  // LW.
    localparam logic [6:0] OP_STORE  = 7'b0100011;  // SW.
    localparam logic [6:0] OP_BRANCH = 7'b1100011;  // BEQ.

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign rs1 = instr[19:15];  // Register fields sit at fixed positions.
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ALU_ADD;
        imm         = '0;
        // Unsupported words end up here and leave every enable low.
        ctrl.illegal = 1'b1;
        unique case (opcode)
            OP_REG: begin
                ctrl.reg_write = 1'b1;
                ctrl.illegal   = 1'b0;
                unique case ({funct7, funct3})
                    {7'b0000000, 3'b000}: ctrl.alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: ctrl.alu_op = ALU_SUB;
                    {7'b0000000, 3'b111}: ctrl.alu_op = ALU_AND;
                    {7'b0000000, 3'b110}: ctrl.alu_op = ALU_OR;
                    {7'b0000000, 3'b100}: ctrl.alu_op = ALU_XOR;
                    {7'b0000000, 3'b010}: ctrl.alu_op = ALU_SLT;
                    default: begin
                        ctrl.reg_write = 1'b0;  // Other R-type forms.
                        ctrl.illegal   = 1'b1;
                    end
                endcase
            end
            OP_IMM, OP_LOAD: begin
                imm = {{20{instr[31]}}, instr[31:20]};  // I-type.
                if ((opcode == OP_IMM && funct3 == 3'b000) ||
                    (opcode == OP_LOAD && funct3 == 3'b010)) begin
                    ctrl.reg_write   = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.mem_to_reg  = (opcode == OP_LOAD);
                    ctrl.illegal     = 1'b0;
                end
            end
            OP_STORE: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};  // S-type.
                if (funct3 == 3'b010) begin  // SW only.
                    ctrl.mem_write   = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.illegal     = 1'b0;
                end
            end
            OP_BRANCH: begin
                imm = {{19{instr[31]}}, instr[31], instr[7],
                       instr[30:25], instr[11:8], 1'b0};  // B-type.
                if (funct3 == 3'b000) begin  // BEQ only.
                    ctrl.branch  = 1'b1;
                    ctrl.alu_op  = ALU_SUB;  // Zero result means equal.
                    ctrl.illegal = 1'b0;
                end
            end
            default: ;
        endcase
    end

endmodule

/* logic/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile
    import rv_pkg::*;
(
    input  logic     CLK,
    input  logic     rst_n,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  reg_idx_t rd,
    input  logic     we,
    input  word_t    wdata,
    output word_t    rdata1,
    output word_t    rdata2
);

    word_t regs [32];  // x0 stays zero, it is never written.

    // Write port. Reset clears the architectural state.
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin
            regs[rd] <= wdata;  // Seen by the next instruction.
        end
    end

    // Read ports, combinational.
    always_comb begin
        rdata1 = regs[rs1];
        rdata2 = regs[rs2];
        if (rs1 == '0) begin
            rdata1 = '0;  // Hard zero.
        end
        if (rs2 == '0) begin
            rdata2 = '0;
        end
    end

endmodule

/* logic/rv_alu.sv */
`timescale 1ns/1ps

module rv_alu
    import rv_pkg::*;
(
    input  word_t   a,
    input  word_t   b,
    input  alu_op_e op,
    output word_t   y,
    output logic    zero
);

    word_t sum;
    word_t diff;
    logic  lt_signed;

    assign sum       = a + b;
    assign diff      = a - b;
    assign lt_signed = ($signed(a) < $signed(b));  // Two's complement order.

    // ------------------------------------------------------------
    // Result select
    // ------------------------------------------------------------
    always_comb begin
        unique case (op)
            ALU_ADD: y = sum;
            ALU_SUB: y = diff;
            ALU_AND: y = a & b;
            ALU_OR:  y = a | b;
            ALU_XOR: y = a ^ b;
            ALU_SLT: y = {31'd0, lt_signed};  // 1 or 0.
            default: y = '0;                  // Unused codes.
        endcase
    end

    // BEQ takes the branch when a - b is zero.
    assign zero = (y == '0);

endmodule

/* logic/rv_core.sv */
`timescale 1ns/1ps

module rv_core
    import rv_pkg::*;
(
    input  logic      CLK,
    input  logic      rst_n,
    input  word_t     idata,     // Instruction at iaddr.
    output word_t     iaddr,
    output dmem_req_t dmem_req,
    input  word_t     rdata      // Loaded word at dmem_req.addr.
);

    // ------------------------------------------------------------
    // Fetch and decode
    // ------------------------------------------------------------
    word_t    pc;
    word_t    pc_next;
    ctrl_t    ctrl;
    word_t    imm;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;

    word_t    rdata1;
    word_t    rdata2;
    word_t    alu_b;
    word_t    alu_y;
    logic     alu_zero;
    word_t    wb_data;
    logic     exec_ok;   // Instruction may change state.

    assign iaddr = pc;

    rv_decoder u_decoder (
        .instr (idata),
        .ctrl  (ctrl),
        .imm   (imm),
        .rs1   (rs1),
        .rs2   (rs2),
        .rd    (rd)
    );

    // Nothing commits while in reset or for an illegal word.
    assign exec_ok = rst_n & ~ctrl.illegal;

    // ------------------------------------------------------------
    // Register file and ALU
    // ------------------------------------------------------------
    rv_regfile u_regfile (
        .CLK    (CLK),
        .rst_n  (rst_n),
        .rs1    (rs1),
        .rs2    (rs2),
        .rd     (rd),
        .we     (ctrl.reg_write & exec_ok),
        .wdata  (wb_data),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    assign alu_b = ctrl.alu_src_imm ? imm : rdata2;  // Immediate or rs2.

    rv_alu u_alu (
        .a    (rdata1),
        .b    (alu_b),
        .op   (ctrl.alu_op),
        .y    (alu_y),
        .zero (alu_zero)
    );

    assign wb_data = ctrl.mem_to_reg ? rdata : alu_y;  // Load or ALU result.

    // Store request. The address comes from rs1 + imm.
    assign dmem_req.we    = ctrl.mem_write & exec_ok;
    assign dmem_req.addr  = alu_y;
    assign dmem_req.wdata = rdata2;

    // ------------------------------------------------------------
    // Program counter
    // ------------------------------------------------------------
    assign pc_next = (ctrl.branch && alu_zero) ? (pc + imm) : (pc + 32'd4);

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            pc <= '0;  // First fetch at index 0.
        end else begin
            pc <= pc_next;
        end
    end

endmodule

/* logic/rv_dmem.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_dmem
    import rv_pkg::*;
#(
    parameter int DEPTH = `RV_DMEM_DEPTH
) (
    input  logic      CLK,
    input  dmem_req_t req,
    output word_t     rdata
);

    word_t     mem [DEPTH];  // Data store, contents survive reset.
    dmem_idx_t idx;
    logic      in_range;

    // Word index from the byte address; low two bits are ignored.
    assign idx      = req.addr[`RV_DMEM_AW+`RV_WORD_OFS-1:`RV_WORD_OFS];
    assign in_range = (int'(idx) < DEPTH);

    // Store lands at the edge ending the request cycle.
    always_ff @(posedge CLK) begin
        if (req.we && in_range) begin
            mem[idx] <= req.wdata;
        end
    end

    // Load path, same-cycle.
    always_comb begin
        if (in_range) begin
            rdata = mem[idx];
        end else begin
            rdata = '0;
        end
    end

endmodule

/* logic/rv_system.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_system
    import rv_pkg::*;
(
    input  logic      CLK,
    input  logic      rst_n,
    input  logic      prog_we,    // Program load, during reset only.
    input  imem_idx_t prog_idx,
    input  word_t     prog_data,
    output word_t     iaddr,      // Fetch address, for observation.
    output dmem_req_t dmem_req    // Store bus, for observation.
);

    word_t idata;
    word_t rdata;

    // ------------------------------------------------------------
    // Instruction side
    // ------------------------------------------------------------
    rv_imem u_imem (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .prog_we   (prog_we),
        .prog_idx  (prog_idx),
        .prog_data (prog_data),
        .idx       (iaddr[`RV_IMEM_AW+`RV_WORD_OFS-1:`RV_WORD_OFS]),
        .idata     (idata)
    );

    rv_core u_core (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .idata    (idata),
        .iaddr    (iaddr),
        .dmem_req (dmem_req),
        .rdata    (rdata)
    );

    // Data side
    rv_dmem u_dmem (
        .CLK   (CLK),
        .req   (dmem_req),
        .rdata (rdata)
    );

endmodule

/* tests/rv_clock_gen.sv */
`timescale 1ns/1ps

module rv_clock_gen #(
    parameter int PERIOD_NS = 20   // Full clock period.
) (
    output logic CLK
);

    initial begin
        CLK = 1'b0;                     // Start low, first rise at half a period.
        forever begin
            #(PERIOD_NS / 2) CLK = ~CLK;
        end
    end

endmodule

/* tests/rv_system_chk.sv */
`timescale 1ns/1ps

module rv_system_chk
    import rv_pkg::*;
(
    input logic      CLK,
    input logic      rst_n,
    input word_t     iaddr,
    input dmem_req_t dmem_req
);

    int fail_count = 0;  // Read by the testbench at the end of the run.

    // ------------------------------------------------------------
    // Store bus and fetch address
    // ------------------------------------------------------------
    no_store_in_reset: assert property (@(posedge CLK) !rst_n |-> !dmem_req.we)
        else begin
            $error("Store strobe high while reset is held.");
            fail_count++;
        end

    iaddr_aligned: assert property (@(posedge CLK) disable iff (!rst_n) iaddr[1:0] == 2'b00)
        else begin
            $error("Fetch address not word aligned.");
            fail_count++;
        end

    // PC is cleared by the first reset edge, so check from the second one on.
    iaddr_zero_in_reset: assert property (@(posedge CLK) (!rst_n ##1 !rst_n) |-> iaddr == '0)
        else begin
            $error("Fetch address not zero during reset.");
            fail_count++;
        end

endmodule

bind rv_system rv_system_chk u_chk (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .iaddr    (iaddr),
    .dmem_req (dmem_req)
);

/* tests/rv_system_tb.sv */
`timescale 1ns/1ps

module rv_system_tb
    import rv_pkg::*;
();

    localparam int CLK_PERIOD = 20;
    localparam int N_TESTS    = 6;
    localparam int MAX_WORDS  = 16;
    localparam int RST_CYCLES = 8;

    typedef struct packed {
        word_t addr;  // Byte address of the store.
        word_t data;  // Stored word.
    } store_t;

    logic      CLK;
    logic      rst_n;
    logic      prog_we;
    imem_idx_t prog_idx;
    word_t     prog_data;
    word_t     iaddr;
    dmem_req_t dmem_req;

    // ------------------------------------------------------------
    // Test table
    // ------------------------------------------------------------
    string  test_name [N_TESTS];
    word_t  prog      [N_TESTS][MAX_WORDS];  // Program image per test.
    int     prog_len  [N_TESTS];
    store_t exp_store [N_TESTS][MAX_WORDS];  // Expected stores, in order.
    int     exp_len   [N_TESTS];

    int   cur_test;
    int   store_idx;            // Next expected store of the running test.
    int   err_count;
    int   wd_cycles;
    logic table_ready = 1'b0;

    rv_clock_gen #(.PERIOD_NS(CLK_PERIOD)) u_clk (.CLK(CLK));

    rv_system uut (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .prog_we   (prog_we),
        .prog_idx  (prog_idx),
        .prog_data (prog_data),
        .iaddr     (iaddr),
        .dmem_req  (dmem_req)
    );

    // ------------------------------------------------------------
    // Instruction encoders
    // ------------------------------------------------------------
    function automatic word_t enc_r(int f7, int f3, int rd, int rs1, int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic word_t enc_addi(int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
    endfunction

    function automatic word_t enc_lw(int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
    endfunction

    function automatic word_t enc_sw(int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t enc_beq(int rs1, int rs2, int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], 3'b000,
                off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic word_t sext12(logic [11:0] v);
        return {{20{v[11]}}, v};  // I-type immediate as the core sees it.
    endfunction

    task automatic add_instr(int t, word_t w);
        prog[t][prog_len[t]] = w;
        prog_len[t]++;
    endtask

    task automatic expect_store(int t, word_t addr, word_t data);
        exp_store[t][exp_len[t]] = '{addr: addr, data: data};
        exp_len[t]++;
    endtask

    task automatic build_table();
        logic [11:0] ia;
        logic [11:0] ib;
        word_t       a;
        word_t       b;
        for (int t = 0; t < N_TESTS; t++) begin
            prog_len[t] = 0;
            exp_len[t]  = 0;
        end
        ia = 12'($urandom()) | 12'h800;          // Always negative.
        ib = 12'($urandom()) & 12'h7ff;          // Always positive or zero.
        a  = sext12(ia);
        b  = sext12(ib);
        test_name[0] = "reset_start";
        add_instr(0, enc_sw(0, 0, 64));          // Index 0 stores at once.
        add_instr(0, enc_addi(1, 0, 5));
        add_instr(0, enc_sw(1, 0, 68));
        add_instr(0, enc_beq(0, 0, 0));          // Self-loop ends the program.
        expect_store(0, 32'd64, 32'd0);
        expect_store(0, 32'd68, 32'd5);
        test_name[1] = "reg_arith";
        add_instr(1, enc_addi(1, 0, int'(ia)));
        add_instr(1, enc_addi(2, 0, int'(ib)));
        add_instr(1, enc_r(7'h00, 3'b000, 3, 1, 2));  // ADD.
        add_instr(1, enc_sw(3, 0, 0));
        add_instr(1, enc_r(7'h20, 3'b000, 3, 1, 2));  // SUB.
        add_instr(1, enc_sw(3, 0, 4));
        add_instr(1, enc_r(7'h00, 3'b111, 3, 1, 2));  // AND.
        add_instr(1, enc_sw(3, 0, 8));
        add_instr(1, enc_r(7'h00, 3'b110, 3, 1, 2));  // OR.
        add_instr(1, enc_sw(3, 0, 12));
        add_instr(1, enc_r(7'h00, 3'b100, 3, 1, 2));  // XOR.
        add_instr(1, enc_sw(3, 0, 16));
        add_instr(1, enc_r(7'h00, 3'b010, 3, 1, 2));  // SLT.
        add_instr(1, enc_sw(3, 0, 20));
        add_instr(1, enc_beq(0, 0, 0));
        expect_store(1, 32'd0, a + b);
        expect_store(1, 32'd4, a - b);
        expect_store(1, 32'd8, a & b);
        expect_store(1, 32'd12, a | b);
        expect_store(1, 32'd16, a ^ b);
        expect_store(1, 32'd20, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        test_name[2] = "sign_ext";
        add_instr(2, enc_addi(1, 0, -100));
        add_instr(2, enc_addi(2, 0, 200));       // Base register.
        add_instr(2, enc_sw(1, 2, -8));
        add_instr(2, enc_addi(3, 1, -28));
        add_instr(2, enc_sw(3, 2, -4));
        add_instr(2, enc_beq(0, 0, 0));
        expect_store(2, 32'd192, 32'hffff_ff9c);
        expect_store(2, 32'd196, 32'hffff_ff80);
        test_name[3] = "mem_round_trip";
        add_instr(3, enc_addi(1, 0, -1366));
        add_instr(3, enc_sw(1, 0, 256));
        add_instr(3, enc_lw(5, 0, 256));         // Read back into x5.
        add_instr(3, enc_sw(5, 0, 260));
        add_instr(3, enc_beq(0, 0, 0));
        expect_store(3, 32'd256, 32'hffff_faaa);
        expect_store(3, 32'd260, 32'hffff_faaa);
        test_name[4] = "branch";
        add_instr(4, enc_addi(1, 0, 7));
        add_instr(4, enc_addi(2, 0, 7));
        add_instr(4, enc_beq(1, 2, 8));          // Taken branch skips the next store.
        add_instr(4, enc_sw(1, 0, 300));
        add_instr(4, enc_sw(2, 0, 304));
        add_instr(4, enc_addi(3, 0, 9));
        add_instr(4, enc_beq(1, 3, 8));          // Not taken.
        add_instr(4, enc_sw(3, 0, 308));
        add_instr(4, enc_beq(0, 0, 0));
        expect_store(4, 32'd304, 32'd7);
        expect_store(4, 32'd308, 32'd9);
        test_name[5] = "x0_illegal";
        add_instr(5, enc_addi(0, 0, 123));       // Write to x0 is dropped.
        add_instr(5, enc_sw(0, 0, 400));
        add_instr(5, enc_addi(1, 0, 42));
        add_instr(5, enc_sw(1, 0, 404));
        add_instr(5, enc_r(7'h7f, 3'b000, 1, 0, 0));  // Bad funct7 that would clear x1.
        add_instr(5, enc_sw(1, 0, 408));
        add_instr(5, enc_beq(0, 0, 0));
        expect_store(5, 32'd400, 32'd0);
        expect_store(5, 32'd404, 32'd42);
        expect_store(5, 32'd408, 32'd42);
    endtask

    // ------------------------------------------------------------
    // Store monitor sampling the bus at the rising edge
    // ------------------------------------------------------------
    always @(posedge CLK) begin
        store_t exp_s;
        if (dmem_req.we) begin
            assert (rst_n && store_idx < exp_len[cur_test]) else begin
                $display("ERROR at %0t: unexpected store to %h in test %s",
                         $time, dmem_req.addr, test_name[cur_test]);
                err_count++;
            end
            if (rst_n && store_idx < exp_len[cur_test]) begin
                exp_s = exp_store[cur_test][store_idx];
                assert (dmem_req.addr == exp_s.addr) else begin
                    $display("CHECK FAILED at %0t: dmem_req.addr expected %h, observed %h",
                             $time, exp_s.addr, dmem_req.addr);
                    err_count++;
                end
                assert (dmem_req.wdata == exp_s.data) else begin
                    $display("CHECK FAILED at %0t: dmem_req.wdata expected %h, observed %h",
                             $time, exp_s.data, dmem_req.wdata);
                    err_count++;
                end
                store_idx++;
            end
        end
    end

    task automatic run_test(int t);
        int    run_len;
        word_t loop_addr;
        run_len   = prog_len[t] + 4;
        loop_addr = word_t'((prog_len[t] - 1) * 4);  // Self-loop is the last word.
        @(negedge CLK);
        cur_test  = t;
        store_idx = 0;
        rst_n     = 1'b0;
        repeat (RST_CYCLES) @(negedge CLK);
        for (int i = 0; i < prog_len[t]; i++) begin
            prog_we   = 1'b1;                    // One word per clock while in reset.
            prog_idx  = imem_idx_t'(i);
            prog_data = prog[t][i];
            @(negedge CLK);
        end
        prog_we = 1'b0;
        rst_n   = 1'b1;
        repeat (run_len) @(posedge CLK);
        @(negedge CLK);                          // Let the last monitor sample settle.
        assert (store_idx == exp_len[t]) else begin
            $display("ERROR at %0t: test %s produced %0d of %0d expected stores",
                     $time, test_name[t], store_idx, exp_len[t]);
            err_count++;
        end
        assert (iaddr == loop_addr) else begin
            $display("CHECK FAILED at %0t: iaddr expected %h, observed %h",
                     $time, loop_addr, iaddr);
            err_count++;
        end
    endtask

    // ------------------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------------------
    initial begin
        int pass_cnt;
        int fail_cnt;
        int errs_before;
        rst_n     = 1'b0;
        prog_we   = 1'b0;
        prog_idx  = '0;
        prog_data = '0;
        cur_test  = 0;
        store_idx = 0;
        err_count = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        void'($urandom(32'ha633));
        build_table();
        wd_cycles = 100;                         // Margin.
        for (int t = 0; t < N_TESTS; t++) begin
            wd_cycles += RST_CYCLES + prog_len[t] + prog_len[t] + 4;
        end
        table_ready = 1'b1;
        for (int t = 0; t < N_TESTS; t++) begin
            errs_before = err_count;
            run_test(t);
            if (err_count == errs_before) begin
                pass_cnt++;
                $display("Test %0d %s: passed", t, test_name[t]);
            end else begin
                fail_cnt++;
                $display("Test %0d %s: failed with %0d errors", t, test_name[t],
                         err_count - errs_before);
            end
        end
        $display("Tests passed %0d, failed %0d, checker assertion failures %0d",
                 pass_cnt, fail_cnt, uut.u_chk.fail_count);
        if (fail_cnt == 0 && uut.u_chk.fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        #(wd_cycles * CLK_PERIOD);
        $display("ERROR: watchdog expired after %0d cycles, the run did not complete",
                 wd_cycles);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* build.f */
+incdir+logic
logic/rv_pkg.sv
logic/rv_imem.sv
logic/rv_decoder.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_core.sv
logic/rv_dmem.sv
logic/rv_system.sv
tests/rv_clock_gen.sv
tests/rv_system_chk.sv
tests/rv_system_tb.sv
